/* compile.f */
+incdir+include
rtl/ddr_rd_pkg.sv
rtl/rd_cand_if.sv
rtl/pkt_req_latch.sv
rtl/relay_table.sv
rtl/rd_phase_ctrl.sv
rtl/rd_cmd_issuer.sv
rtl/ddr_rd_sched_top.sv
tests/tb_ddr_rd_sched.sv

/* include/ddr_rd_consts.svh */
`ifndef DDR_RD_CONSTS_SVH
`define DDR_RD_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Read command fields
////////////////////////////////////////////////////////////////////////////

// Byte count of one read, one word
`define DDR_RD_BYTE_W       32

// Destination queue number
`define DDR_RD_QUEUE_W      3

////////////////////////////////////////////////////////////////////////////
// Relay table
////////////////////////////////////////////////////////////////////////////

`define DDR_RD_QUEUE_NUM    8

`endif

/* rtl/ddr_rd_pkg.sv */
`default_nettype none

`include "ddr_rd_consts.svh"

package ddr_rd_pkg;

    typedef logic [`DDR_RD_BYTE_W-1:0]  byte_cnt_t;
    typedef logic [`DDR_RD_QUEUE_W-1:0] queue_id_t;

    // Scheduler round, served in this order
    typedef enum logic [2:0] {
        IDLE,
        UNLOCAL,
        MY_TWO,
        RECV_TWO,
        LOCAL,
        RELAY
    } rd_phase_t;

    // Unlocal, own two-hop and local sources
    typedef struct packed {
        byte_cnt_t bytes;
        queue_id_t queue;
    } direct_req_t;

    // Received two-hop, the forwarding engine picks the queue
    typedef struct packed {
        byte_cnt_t bytes;
    } fwd_req_t;

    // Queue 0 sits in the lowest word
    typedef byte_cnt_t [`DDR_RD_QUEUE_NUM-1:0] relay_cnt_t;

endpackage

`default_nettype wire

/* rtl/ddr_rd_sched_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_rd_consts.svh"

module ddr_rd_sched_top (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire                   i_unlocal_valid,
    input  wire ddr_rd_pkg::byte_cnt_t i_unlocal_bytes,
    input  wire ddr_rd_pkg::queue_id_t i_unlocal_queue,
    input  wire                   i_my_two_valid,
    input  wire ddr_rd_pkg::byte_cnt_t i_my_two_bytes,
    input  wire ddr_rd_pkg::queue_id_t i_my_two_queue,
    input  wire                   i_local_valid,
    input  wire ddr_rd_pkg::byte_cnt_t i_local_bytes,
    input  wire ddr_rd_pkg::queue_id_t i_local_queue,
    input  wire                   i_recv_two_valid,
    input  wire ddr_rd_pkg::byte_cnt_t i_recv_two_bytes,
    input  wire                   i_relay_valid,
    input  wire [`DDR_RD_QUEUE_NUM*`DDR_RD_BYTE_W-1:0] i_relay_bytes,
    output logic                  o_rd_flag,
    output ddr_rd_pkg::queue_id_t o_rd_queue,
    output ddr_rd_pkg::byte_cnt_t o_rd_bytes,
    output logic                  o_rd_valid,
    input  wire                   i_rd_ready,
    input  wire                   i_rd_queue_finish,
    input  wire                   i_forward_req,
    output logic                  o_forward_resp,
    input  wire                   i_forward_finish,
    output logic                  o_forward_valid
);

import ddr_rd_pkg::*;

direct_req_t w_unlocal_in, w_my_two_in, w_local_in;
direct_req_t w_unlocal_req, w_my_two_req, w_local_req;
fwd_req_t    w_recv_two_in, w_recv_two_req;
logic        w_unlocal_vld, w_my_two_vld, w_recv_two_vld, w_local_vld;
logic        w_unlocal_clr, w_my_two_clr, w_recv_two_clr, w_local_clr;
relay_cnt_t  w_relay_counts;
rd_phase_t   w_phase;
logic        w_relay_load_en;
logic        w_relay_advance;
logic        w_head_valid;
queue_id_t   w_head_queue;
byte_cnt_t   w_head_bytes;
logic        w_all_done;

rd_cand_if cand_bus ();

assign w_unlocal_in   = '{bytes: i_unlocal_bytes, queue: i_unlocal_queue};
assign w_my_two_in    = '{bytes: i_my_two_bytes, queue: i_my_two_queue};
assign w_local_in     = '{bytes: i_local_bytes, queue: i_local_queue};
assign w_recv_two_in  = '{bytes: i_recv_two_bytes};
assign w_relay_counts = i_relay_bytes;

////////////////////////////////////////////////////////////////////////////
// Source latches
////////////////////////////////////////////////////////////////////////////

pkt_req_latch #(.T(direct_req_t)) unlocal_latch_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_unlocal_valid), .i_req(w_unlocal_in),
    .i_clear(w_unlocal_clr), .o_valid(w_unlocal_vld), .o_req(w_unlocal_req)
);

pkt_req_latch #(.T(direct_req_t)) my_two_latch_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_my_two_valid), .i_req(w_my_two_in),
    .i_clear(w_my_two_clr), .o_valid(w_my_two_vld), .o_req(w_my_two_req)
);

pkt_req_latch #(.T(fwd_req_t)) recv_two_latch_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_recv_two_valid), .i_req(w_recv_two_in),
    .i_clear(w_recv_two_clr), .o_valid(w_recv_two_vld), .o_req(w_recv_two_req)
);

pkt_req_latch #(.T(direct_req_t)) local_latch_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_local_valid), .i_req(w_local_in),
    .i_clear(w_local_clr), .o_valid(w_local_vld), .o_req(w_local_req)
);

// Table empties while idle, loads only mid-round
relay_table relay_table_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_load       (i_relay_valid && w_relay_load_en),
    .i_counts     (w_relay_counts),
    .i_flush      (w_phase == IDLE),
    .i_advance    (w_relay_advance),
    .o_head_valid (w_head_valid),
    .o_head_queue (w_head_queue),
    .o_head_bytes (w_head_bytes),
    .o_all_done   (w_all_done)
);

rd_phase_ctrl phase_ctrl_i (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_unlocal_start  (i_unlocal_valid),
    .i_unlocal_valid  (w_unlocal_vld),
    .i_unlocal_req    (w_unlocal_req),
    .i_my_two_valid   (w_my_two_vld),
    .i_my_two_req     (w_my_two_req),
    .i_recv_two_valid (w_recv_two_vld),
    .i_recv_two_req   (w_recv_two_req),
    .i_local_valid    (w_local_vld),
    .i_local_req      (w_local_req),
    .i_head_valid     (w_head_valid),
    .i_head_queue     (w_head_queue),
    .i_head_bytes     (w_head_bytes),
    .i_all_done       (w_all_done),
    .i_forward_req    (i_forward_req),
    .i_forward_finish (i_forward_finish),
    .o_phase          (w_phase),
    .o_unlocal_clear  (w_unlocal_clr),
    .o_my_two_clear   (w_my_two_clr),
    .o_recv_two_clear (w_recv_two_clr),
    .o_local_clear    (w_local_clr),
    .o_relay_load_en  (w_relay_load_en),
    .o_relay_advance  (w_relay_advance),
    .o_forward_resp   (o_forward_resp),
    .o_forward_valid  (o_forward_valid),
    .cand             (cand_bus)
);

rd_cmd_issuer cmd_issuer_i (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .cand              (cand_bus),
    .i_rd_ready        (i_rd_ready),
    .i_rd_queue_finish (i_rd_queue_finish),
    .o_rd_flag         (o_rd_flag),
    .o_rd_queue        (o_rd_queue),
    .o_rd_bytes        (o_rd_bytes),
    .o_rd_valid        (o_rd_valid)
);

endmodule

`default_nettype wire

/* rtl/pkt_req_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_req_latch #(
    parameter type T = logic
) (
    input  wire   i_clk,
    input  wire   i_rst,
    input  wire   i_valid,
    input  wire T i_req,
    input  wire   i_clear,
    output logic  o_valid,
    output T      o_req
);

// A new request wins over a clear in the same cycle
always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        o_valid <= 1'b0;
    end else if (i_valid) begin
        o_valid <= 1'b1;
    end else if (i_clear) begin
        o_valid <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (i_valid) begin
        o_req <= i_req;
    end
end

endmodule

`default_nettype wire

/* rtl/rd_cand_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface rd_cand_if;

    import ddr_rd_pkg::*;

    logic      cand_valid;
    logic      cand_flag;
    queue_id_t cand_queue;
    byte_cnt_t cand_bytes;
    // Command accepted and its queue-finish seen
    logic      cmd_done;

    modport ctrl (
        output cand_valid,
        output cand_flag,
        output cand_queue,
        output cand_bytes,
        input  cmd_done
    );

    modport issuer (
        input  cand_valid,
        input  cand_flag,
        input  cand_queue,
        input  cand_bytes,
        output cmd_done
    );

endinterface

`default_nettype wire

/* rtl/rd_cmd_issuer.sv */
`timescale 1ns/100ps
`default_nettype none

module rd_cmd_issuer (
    input  wire                   i_clk,
    input  wire                   i_rst,
    rd_cand_if.issuer             cand,
    input  wire                   i_rd_ready,
    input  wire                   i_rd_queue_finish,
    output logic                  o_rd_flag,
    output ddr_rd_pkg::queue_id_t o_rd_queue,
    output ddr_rd_pkg::byte_cnt_t o_rd_bytes,
    output logic                  o_rd_valid
);

// Held from handshake until queue-finish
logic r_lock;
logic w_issue;

assign w_issue = cand.cand_valid && !o_rd_valid && !r_lock;

always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        o_rd_valid <= 1'b0;
        r_lock     <= 1'b0;
    end else if (o_rd_valid) begin
        if (i_rd_ready) begin
            o_rd_valid <= 1'b0;
            r_lock     <= 1'b1;
        end
    end else if (r_lock) begin
        if (i_rd_queue_finish) begin
            r_lock <= 1'b0;
        end
    end else if (w_issue) begin
        o_rd_valid <= 1'b1;
    end
end

// Command fields stay put while valid is high
always_ff @(posedge i_clk) begin
    if (w_issue) begin
        o_rd_flag  <= cand.cand_flag;
        o_rd_queue <= cand.cand_queue;
        o_rd_bytes <= cand.cand_bytes;
    end
end

assign cand.cmd_done = r_lock && i_rd_queue_finish;

endmodule

`default_nettype wire

/* rtl/rd_phase_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rd_phase_ctrl (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_unlocal_start,
    input  wire                     i_unlocal_valid,
    input  wire ddr_rd_pkg::direct_req_t i_unlocal_req,
    input  wire                     i_my_two_valid,
    input  wire ddr_rd_pkg::direct_req_t i_my_two_req,
    input  wire                     i_recv_two_valid,
    input  wire ddr_rd_pkg::fwd_req_t    i_recv_two_req,
    input  wire                     i_local_valid,
    input  wire ddr_rd_pkg::direct_req_t i_local_req,
    input  wire                     i_head_valid,
    input  wire ddr_rd_pkg::queue_id_t   i_head_queue,
    input  wire ddr_rd_pkg::byte_cnt_t   i_head_bytes,
    input  wire                     i_all_done,
    input  wire                     i_forward_req,
    input  wire                     i_forward_finish,
    output ddr_rd_pkg::rd_phase_t   o_phase,
    output logic                    o_unlocal_clear,
    output logic                    o_my_two_clear,
    output logic                    o_recv_two_clear,
    output logic                    o_local_clear,
    output logic                    o_relay_load_en,
    output logic                    o_relay_advance,
    output logic                    o_forward_resp,
    output logic                    o_forward_valid,
    rd_cand_if.ctrl                 cand
);

import ddr_rd_pkg::*;

rd_phase_t r_phase;
rd_phase_t w_nxt_phase;
logic      w_unlocal_skip;
logic      w_my_two_skip;
logic      w_recv_two_skip;
logic      w_local_skip;
logic      w_round_end;

assign w_unlocal_skip  = i_unlocal_valid && (i_unlocal_req.bytes == '0);
assign w_my_two_skip   = i_my_two_valid && (i_my_two_req.bytes == '0);
assign w_recv_two_skip = i_recv_two_valid && (i_recv_two_req.bytes == '0);
assign w_local_skip    = i_local_valid && (i_local_req.bytes == '0);

always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        r_phase <= IDLE;
    end else begin
        r_phase <= w_nxt_phase;
    end
end

always_comb begin
    w_nxt_phase = r_phase;
    case (r_phase)
        IDLE:     if (i_unlocal_start) w_nxt_phase = UNLOCAL;
        UNLOCAL:  if (w_unlocal_skip || cand.cmd_done) w_nxt_phase = MY_TWO;
        MY_TWO:   if (w_my_two_skip || (i_my_two_valid && cand.cmd_done)) w_nxt_phase = RECV_TWO;
        RECV_TWO: begin
            if (w_recv_two_skip || (i_recv_two_valid && i_forward_finish)) begin
                w_nxt_phase = LOCAL;
            end
        end
        LOCAL:    if (w_local_skip || (i_local_valid && cand.cmd_done)) w_nxt_phase = RELAY;
        RELAY:    if (i_all_done) w_nxt_phase = IDLE;
        default:  w_nxt_phase = IDLE;
    endcase
end

////////////////////////////////////////////////////////////////////////////
// Candidate routing, flag set for unlocal only
////////////////////////////////////////////////////////////////////////////

always_comb begin
    cand.cand_valid = 1'b0;
    cand.cand_flag  = 1'b0;
    cand.cand_queue = '0;
    cand.cand_bytes = '0;
    case (r_phase)
        UNLOCAL: begin
            cand.cand_valid = i_unlocal_valid && !w_unlocal_skip;
            cand.cand_flag  = 1'b1;
            cand.cand_queue = i_unlocal_req.queue;
            cand.cand_bytes = i_unlocal_req.bytes;
        end
        MY_TWO: begin
            cand.cand_valid = i_my_two_valid && !w_my_two_skip;
            cand.cand_queue = i_my_two_req.queue;
            cand.cand_bytes = i_my_two_req.bytes;
        end
        LOCAL: begin
            cand.cand_valid = i_local_valid && !w_local_skip;
            cand.cand_queue = i_local_req.queue;
            cand.cand_bytes = i_local_req.bytes;
        end
        RELAY: begin
            cand.cand_valid = i_head_valid;
            cand.cand_queue = i_head_queue;
            cand.cand_bytes = i_head_bytes;
        end
        default: ;
    endcase
end

// Forward engine handshake
always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        o_forward_resp <= 1'b0;
    end else if (o_forward_resp && i_forward_req) begin
        o_forward_resp <= 1'b0;
    end else if ((r_phase == RECV_TWO) && i_forward_req) begin
        o_forward_resp <= 1'b1;
    end
end

assign w_round_end      = (r_phase == RELAY) && (w_nxt_phase == IDLE);
assign o_phase          = r_phase;
assign o_unlocal_clear  = (r_phase == UNLOCAL) && (w_nxt_phase == MY_TWO);
assign o_my_two_clear   = w_round_end;
assign o_recv_two_clear = w_round_end;
assign o_local_clear    = w_round_end;
assign o_relay_load_en  = (r_phase != IDLE) && (r_phase != RELAY);
assign o_relay_advance  = (r_phase == RELAY) && cand.cmd_done;
assign o_forward_valid  = (r_phase == RECV_TWO);

endmodule

`default_nettype wire

/* rtl/relay_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_rd_consts.svh"

module relay_table (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire                   i_load,
    input  wire ddr_rd_pkg::relay_cnt_t i_counts,
    input  wire                   i_flush,
    input  wire                   i_advance,
    output logic                  o_head_valid,
    output ddr_rd_pkg::queue_id_t o_head_queue,
    output ddr_rd_pkg::byte_cnt_t o_head_bytes,
    output logic                  o_all_done
);

import ddr_rd_pkg::*;

relay_cnt_t                    r_counts;
logic [`DDR_RD_QUEUE_NUM-1:0]  r_pending;
queue_id_t                     w_head_idx;

always_ff @(posedge i_clk) begin
    if (i_flush) begin
        r_counts <= '0;
    end else if (i_load) begin
        r_counts <= i_counts;
    end
end

// Empty queues never become pending
always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        r_pending <= '0;
    end else if (i_flush) begin
        r_pending <= '0;
    end else if (i_load) begin
        for (int i = 0; i < `DDR_RD_QUEUE_NUM; i++) begin
            r_pending[i] <= (i_counts[i] != '0);
        end
    end else if (i_advance) begin
        r_pending[w_head_idx] <= 1'b0;
    end
end

////////////////////////////////////////////////////////////////////////////
// Lowest pending index is the head
////////////////////////////////////////////////////////////////////////////

always_comb begin
    w_head_idx = '0;
    for (int i = `DDR_RD_QUEUE_NUM - 1; i >= 0; i--) begin
        if (r_pending[i]) begin
            w_head_idx = queue_id_t'(i);
        end
    end
end

assign o_head_valid = |r_pending;
assign o_head_queue = w_head_idx;
assign o_head_bytes = r_counts[w_head_idx];
assign o_all_done   = ~|r_pending;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the DDR read scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f compile.f --top-module tb_ddr_rd_sched \
    -Mdir obj_dir -o sim_ddr_rd_sched
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_ddr_rd_sched)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* tests/tb_ddr_rd_sched.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_rd_consts.svh"

module tb_ddr_rd_sched;

import ddr_rd_pkg::*;

localparam int NUM_ROWS   = 5;
localparam int MAX_CYCLES = NUM_ROWS * 12 * 16;
// Zero-count phases still take one cycle each
localparam int SETTLE     = 6;

typedef struct {
    byte_cnt_t  unl_bytes;
    queue_id_t  unl_queue;
    byte_cnt_t  two_bytes;
    queue_id_t  two_queue;
    byte_cnt_t  loc_bytes;
    queue_id_t  loc_queue;
    byte_cnt_t  recv_bytes;
    relay_cnt_t relay;
    int         stall;
} round_t;

typedef struct packed {
    logic      flag;
    queue_id_t queue;
    byte_cnt_t bytes;
} rd_cmd_t;

logic       i_clk;
logic       i_rst;
logic       i_unlocal_valid, i_my_two_valid, i_local_valid, i_recv_two_valid;
byte_cnt_t  i_unlocal_bytes, i_my_two_bytes, i_local_bytes, i_recv_two_bytes;
queue_id_t  i_unlocal_queue, i_my_two_queue, i_local_queue;
logic       i_relay_valid;
relay_cnt_t i_relay_bytes;
logic       i_rd_ready, i_rd_queue_finish;
logic       i_forward_req, i_forward_finish;
logic       o_rd_flag, o_rd_valid, o_forward_resp, o_forward_valid;
queue_id_t  o_rd_queue;
byte_cnt_t  o_rd_bytes;

round_t     table_rows [NUM_ROWS];
rd_cmd_t    exp_q [$];
rd_cmd_t    held_cmd;
logic       held_stall, locked, idle_window, recv_exp, fwd_finished;
int         n_cmds, cmd_base, pre_fwd_abs, fwd_base, row_stall, round_id;
int         hs_cnt, fin_cnt, fwd_hs_cnt, cycles;

ddr_rd_sched_top dut_i (.*);

initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
end

task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_rd_cmd(input logic got_flag, input queue_id_t got_queue,
                            input byte_cnt_t got_bytes, input logic exp_flag,
                            input queue_id_t exp_queue, input byte_cnt_t exp_bytes,
                            input string what);
    if (got_flag !== exp_flag || got_queue !== exp_queue || got_bytes !== exp_bytes) begin
        fail_run($sformatf("MISMATCH at %0t: %s (flag %0b/%0b queue %0d/%0d bytes %0d/%0d)",
                           $time, what, got_flag, exp_flag, got_queue, exp_queue,
                           got_bytes, exp_bytes));
    end
endtask

task automatic check_rd_valid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: %s (rd valid %0b, expected %0b)",
                           $time, what, got, exp));
    end
endtask

task automatic check_forward(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: %s (got %0b, expected %0b)",
                           $time, what, got, exp));
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus table, relay counts listed from queue 7 down to queue 0
////////////////////////////////////////////////////////////////////////////

task automatic fill_table();
    table_rows[0] = '{32'd64, 3'd3, 32'd128, 3'd1, 32'd256, 3'd6, 32'd512,
                      {32'd8, 32'd0, 32'd48, 32'd0, 32'd0, 32'd32, 32'd0, 32'd16}, 0};
    table_rows[1] = '{32'd0, 3'd1, 32'd0, 3'd4, 32'd100, 3'd2, 32'd0, '0, 0};
    // Long back-pressure on the first command
    table_rows[2] = '{32'd200, 3'd7, 32'd0, 3'd5, 32'd0, 3'd3, 32'd300,
                      {32'd0, 32'd0, 32'd0, 32'd12, 32'd4, 32'd0, 32'd4, 32'd0}, 20};
    table_rows[3] = '{32'd0, 3'd0, 32'd0, 3'd0, 32'd0, 3'd0, 32'd0, '0, 0};
    table_rows[4] = '{32'd9, 3'd0, 32'd18, 3'd2, 32'd27, 3'd4, 32'd77,
                      {32'd80, 32'd70, 32'd60, 32'd50, 32'd40, 32'd30, 32'd20, 32'd10}, 0};
endtask

// Round order: unlocal, own two-hop, local, relay by queue index
task automatic load_expected(input round_t row);
    exp_q.delete();
    if (row.unl_bytes != '0) begin
        exp_q.push_back({1'b1, row.unl_queue, row.unl_bytes});
    end
    if (row.two_bytes != '0) begin
        exp_q.push_back({1'b0, row.two_queue, row.two_bytes});
    end
    pre_fwd_abs = hs_cnt + exp_q.size();
    if (row.loc_bytes != '0) begin
        exp_q.push_back({1'b0, row.loc_queue, row.loc_bytes});
    end
    for (int i = 0; i < `DDR_RD_QUEUE_NUM; i++) begin
        if (row.relay[i] != '0) begin
            exp_q.push_back({1'b0, queue_id_t'(i), row.relay[i]});
        end
    end
    n_cmds       = exp_q.size();
    cmd_base     = hs_cnt;
    fwd_base     = fwd_hs_cnt;
    recv_exp     = (row.recv_bytes != '0);
    fwd_finished = 1'b0;
    row_stall    = row.stall;
    round_id     = round_id + 1;
endtask

task automatic apply_row(input round_t row);
    @(posedge i_clk);
    i_my_two_valid   <= 1'b1;
    i_my_two_bytes   <= row.two_bytes;
    i_my_two_queue   <= row.two_queue;
    i_recv_two_valid <= 1'b1;
    i_recv_two_bytes <= row.recv_bytes;
    i_local_valid    <= 1'b1;
    i_local_bytes    <= row.loc_bytes;
    i_local_queue    <= row.loc_queue;
    @(posedge i_clk);
    i_my_two_valid   <= 1'b0;
    i_recv_two_valid <= 1'b0;
    i_local_valid    <= 1'b0;
    i_unlocal_valid  <= 1'b1;
    i_unlocal_bytes  <= row.unl_bytes;
    i_unlocal_queue  <= row.unl_queue;
    idle_window = 1'b0;
    @(posedge i_clk);
    i_unlocal_valid  <= 1'b0;
    // Relay table only loads once the round is under way
    i_relay_valid    <= 1'b1;
    i_relay_bytes    <= row.relay;
    @(posedge i_clk);
    i_relay_valid    <= 1'b0;
endtask

// Forwarding engine: one request, one response, then finish
task automatic forward_engine();
    int lag;
    @(negedge i_clk);
    while (!o_forward_valid) @(negedge i_clk);
    @(posedge i_clk);
    i_forward_req <= 1'b1;
    @(negedge i_clk);
    while (!o_forward_resp) @(negedge i_clk);
    @(posedge i_clk);
    i_forward_req <= 1'b0;
    lag = int'($urandom % 3);
    repeat (lag) @(posedge i_clk);
    i_forward_finish <= 1'b1;
    @(posedge i_clk);
    i_forward_finish <= 1'b0;
    fwd_finished = 1'b1;
endtask

// Memory side, ready after 0..3 cycles and finish 1..4 cycles after handshake
initial begin : memory_side
    int gap;
    int lag;
    int served_round;
    served_round = 0;
    i_rd_ready = 1'b0;
    i_rd_queue_finish = 1'b0;
    forever begin
        @(negedge i_clk);
        if (!i_rst && o_rd_valid && !i_rd_ready) begin
            gap = int'($urandom % 4);
            if (served_round != round_id) begin
                served_round = round_id;
                gap = (row_stall > 0) ? row_stall : gap;
            end
            repeat (gap + 1) @(posedge i_clk);
            i_rd_ready <= 1'b1;
            @(posedge i_clk);
            i_rd_ready <= 1'b0;
            lag = int'($urandom % 4);
            repeat (lag) @(posedge i_clk);
            i_rd_queue_finish <= 1'b1;
            @(posedge i_clk);
            i_rd_queue_finish <= 1'b0;
        end
    end
end

////////////////////////////////////////////////////////////////////////////
// Output monitor, sampled mid-cycle
////////////////////////////////////////////////////////////////////////////

always @(negedge i_clk) begin : monitor
    int idx;
    if (i_rst) begin
        hs_cnt     = 0;
        fin_cnt    = 0;
        fwd_hs_cnt = 0;
        cycles     = 0;
        locked     = 1'b0;
        held_stall = 1'b0;
    end else begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            fail_run("Timeout: the scheduler stopped making progress");
        end
        if (idle_window) begin
            check_rd_valid(o_rd_valid, 1'b0, "read valid between rounds");
            check_forward(o_forward_valid, 1'b0, "forward valid between rounds");
            check_forward(o_forward_resp, 1'b0, "forward response between rounds");
        end
        if (locked) begin
            check_rd_valid(o_rd_valid, 1'b0, "new read valid before queue finish");
        end
        if (held_stall) begin
            check_rd_valid(o_rd_valid, 1'b1, "read valid dropped without ready");
            check_rd_cmd(o_rd_flag, o_rd_queue, o_rd_bytes, held_cmd.flag,
                         held_cmd.queue, held_cmd.bytes, "command changed under back-pressure");
        end
        if (o_forward_valid) begin
            check_forward(fin_cnt == pre_fwd_abs && !locked && !o_rd_valid, 1'b1,
                          "forward phase outside its slot");
        end
        if (i_forward_req && o_forward_resp) begin
            fwd_hs_cnt = fwd_hs_cnt + 1;
        end
        if (o_rd_valid && i_rd_ready) begin
            idx = hs_cnt - cmd_base;
            if (idx >= exp_q.size()) begin
                fail_run("A read command was issued that the round does not contain");
            end
            check_rd_cmd(o_rd_flag, o_rd_queue, o_rd_bytes, exp_q[idx].flag,
                         exp_q[idx].queue, exp_q[idx].bytes, "read command");
            if (recv_exp && hs_cnt >= pre_fwd_abs) begin
                check_forward(fwd_finished, 1'b1, "read command before forward finish");
            end
            hs_cnt = hs_cnt + 1;
            locked = 1'b1;
        end
        if (i_rd_queue_finish) begin
            locked  = 1'b0;
            fin_cnt = fin_cnt + 1;
        end
        held_stall = o_rd_valid && !i_rd_ready;
        held_cmd   = {o_rd_flag, o_rd_queue, o_rd_bytes};
    end
end

initial begin : stimulus
    void'($urandom(75991));
    i_rst            = 1'b1;
    i_unlocal_valid  = 1'b0;
    i_unlocal_bytes  = '0;
    i_unlocal_queue  = '0;
    i_my_two_valid   = 1'b0;
    i_my_two_bytes   = '0;
    i_my_two_queue   = '0;
    i_local_valid    = 1'b0;
    i_local_bytes    = '0;
    i_local_queue    = '0;
    i_recv_two_valid = 1'b0;
    i_recv_two_bytes = '0;
    i_relay_valid    = 1'b0;
    i_relay_bytes    = '0;
    i_forward_req    = 1'b0;
    i_forward_finish = 1'b0;
    idle_window      = 1'b1;
    recv_exp         = 1'b0;
    fwd_finished     = 1'b0;
    round_id         = 0;
    row_stall        = 0;
    cmd_base         = 0;
    pre_fwd_abs      = 0;
    fill_table();
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    repeat (3) @(posedge i_clk);

    for (int r = 0; r < NUM_ROWS; r++) begin
        load_expected(table_rows[r]);
        if (recv_exp) begin
            fork
                forward_engine();
            join_none
        end
        apply_row(table_rows[r]);
        while (fin_cnt < cmd_base + n_cmds || (recv_exp && !fwd_finished)) begin
            @(posedge i_clk);
        end
        repeat (SETTLE) @(posedge i_clk);
        check_forward(fwd_hs_cnt - fwd_base == (recv_exp ? 1 : 0), 1'b1,
                      "one forward response per request");
        idle_window = 1'b1;
        repeat (3) @(posedge i_clk);
    end

    repeat (4) @(posedge i_clk);
    $display("Done: no errors");
    $finish;
end

endmodule

`default_nettype wire
